/* logic/bp_pkg.sv */
package bp_pkg;

	//******************************
	// widths
	//******************************
	localparam int PC_W  = 32;
	// history length, also gshare and choice index width
	localparam int GHR_W = 8;

	typedef logic [PC_W-1:0]  pc_t;
	// newest outcome sits in bit 0
	typedef logic [GHR_W-1:0] ghr_t;

	//******************************
	// two-bit counter
	//******************************
	// top bit is the predicted direction
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} ctr_e;

	//******************************
	// snapshot and resolve
	//******************************
	// carried with the branch from lookup to resolve
	typedef struct packed {
		logic taken;
		logic local_taken;
		logic global_taken;
		ghr_t ghr;
	} bp_predict_t;

	typedef struct packed {
		pc_t         pc;
		logic        taken;
		bp_predict_t pred;
	} bp_resolve_t;

	// one step toward taken or not-taken, saturating at both ends
	function automatic ctr_e ctr_step(input ctr_e cur, input logic up);
		ctr_e nxt;
		nxt = cur;
		case (cur)
			STRONG_NT: nxt = up ? WEAK_NT : STRONG_NT;
			WEAK_NT:   nxt = up ? WEAK_T : STRONG_NT;
			WEAK_T:    nxt = up ? STRONG_T : WEAK_NT;
			STRONG_T:  nxt = up ? STRONG_T : WEAK_T;
			default:   nxt = WEAK_NT;
		endcase
		return nxt;
	endfunction

endpackage

/* logic/history_ctrl.sv */
`timescale 1ns/100ps

module history_ctrl (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                lookup_i,
	input  logic                predict_taken_i,
	input  logic                resolve_valid_i,
	input  bp_pkg::bp_resolve_t resolve_i,
	output bp_pkg::ghr_t        ghr_o,
	output logic                upd_tables_o,
	output logic                upd_choice_o,
	output logic                prefer_global_o
);

	localparam int GW = bp_pkg::GHR_W;

	bp_pkg::ghr_t ghr_q;
	bp_pkg::ghr_t ghr_repair;
	logic         mispredict;

	//******************************
	// speculative history
	//******************************
	assign mispredict = resolve_valid_i && (resolve_i.taken != resolve_i.pred.taken);

	// history as it was at lookup with the real outcome shifted in
	assign ghr_repair = {resolve_i.pred.ghr[GW-2:0], resolve_i.taken};

	// repair wins over a lookup in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ghr_q <= '0;
		end else if (mispredict) begin
			ghr_q <= ghr_repair;
		end else if (lookup_i) begin
			ghr_q <= {ghr_q[GW-2:0], predict_taken_i};
		end
	end

	assign ghr_o = ghr_q;

	//******************************
	// training strobes
	//******************************
	assign upd_tables_o = resolve_valid_i;

	// choice only learns when the two sources disagreed
	assign upd_choice_o = resolve_valid_i &&
		(resolve_i.pred.local_taken != resolve_i.pred.global_taken);

	// toward global when global got it right
	assign prefer_global_o = (resolve_i.pred.global_taken == resolve_i.taken);

	// training with an unknown outcome would corrupt all three tables
	a_resolve_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		resolve_valid_i |-> !$isunknown(resolve_i.taken));

endmodule

/* logic/local_predictor.sv */
`timescale 1ns/100ps

module local_predictor #(
	parameter int LOCAL_IDX_W = 6
) (
	input  logic                clk,
	input  logic                rst_n_i,
	input  bp_pkg::pc_t         lookup_pc_i,
	input  logic                upd_i,
	input  bp_pkg::bp_resolve_t resolve_i,
	output logic                local_taken_o
);

	localparam int LOCAL_SIZE = 1 << LOCAL_IDX_W;

	bp_pkg::ctr_e           ctr_tbl [LOCAL_SIZE];
	logic [LOCAL_IDX_W-1:0] rd_idx;
	logic [LOCAL_IDX_W-1:0] wr_idx;
	bp_pkg::ctr_e           rd_ctr;

	//******************************
	// indexing
	//******************************
	// word address bits above the byte offset
	assign rd_idx = lookup_pc_i[LOCAL_IDX_W+1:2];
	assign wr_idx = resolve_i.pc[LOCAL_IDX_W+1:2];

	// combinational read
	assign rd_ctr        = ctr_tbl[rd_idx];
	assign local_taken_o = rd_ctr[1];

	//******************************
	// training
	//******************************
	// every resolved branch moves its own counter
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < LOCAL_SIZE; i++) begin
				ctr_tbl[i] <= bp_pkg::WEAK_NT;
			end
		end else if (upd_i) begin
			ctr_tbl[wr_idx] <= bp_pkg::ctr_step(ctr_tbl[wr_idx], resolve_i.taken);
		end
	end

	// counter seen at lookup must be one of the four states
	a_ctr_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
		rd_ctr inside {bp_pkg::STRONG_NT, bp_pkg::WEAK_NT, bp_pkg::WEAK_T,
			bp_pkg::STRONG_T});

endmodule

/* logic/gshare_predictor.sv */
`timescale 1ns/100ps

module gshare_predictor (
	input  logic                clk,
	input  logic                rst_n_i,
	input  bp_pkg::pc_t         lookup_pc_i,
	input  bp_pkg::ghr_t        ghr_i,
	input  logic                upd_i,
	input  bp_pkg::bp_resolve_t resolve_i,
	output logic                global_taken_o
);

	localparam int GW      = bp_pkg::GHR_W;
	localparam int GS_SIZE = 1 << GW;

	bp_pkg::ctr_e ctr_tbl [GS_SIZE];
	bp_pkg::ghr_t rd_idx;
	bp_pkg::ghr_t wr_idx;
	bp_pkg::ctr_e rd_ctr;

	//******************************
	// indexing
	//******************************
	// lookup hashes with the live history
	assign rd_idx = lookup_pc_i[GW+1:2] ^ ghr_i;

	// training hashes with the history the branch saw at lookup,
	// so the same entry is found even after later shifts or a repair
	assign wr_idx = resolve_i.pc[GW+1:2] ^ resolve_i.pred.ghr;

	assign rd_ctr         = ctr_tbl[rd_idx];
	assign global_taken_o = rd_ctr[1];

	//******************************
	// training
	//******************************
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < GS_SIZE; i++) begin
				ctr_tbl[i] <= bp_pkg::WEAK_NT;
			end
		end else if (upd_i) begin
			ctr_tbl[wr_idx] <= bp_pkg::ctr_step(ctr_tbl[wr_idx], resolve_i.taken);
		end
	end

endmodule

/* logic/tournament_select.sv */
`timescale 1ns/100ps

module tournament_select (
	input  logic                clk,
	input  logic                rst_n_i,
	input  bp_pkg::pc_t         lookup_pc_i,
	input  bp_pkg::ghr_t        ghr_i,
	input  logic                local_taken_i,
	input  logic                global_taken_i,
	input  logic                upd_i,
	input  logic                prefer_global_i,
	input  bp_pkg::bp_resolve_t resolve_i,
	output bp_pkg::bp_predict_t predict_o
);

	localparam int GW      = bp_pkg::GHR_W;
	localparam int CH_SIZE = 1 << GW;

	// taken side of a choice counter means global
	bp_pkg::ctr_e      choice_tbl [CH_SIZE];
	logic [GW-1:0]     rd_idx;
	logic [GW-1:0]     wr_idx;
	bp_pkg::ctr_e      rd_choice;
	logic              use_global;
	logic              final_taken;

	//******************************
	// choice lookup
	//******************************
	// plain pc index, no history
	assign rd_idx = lookup_pc_i[GW+1:2];
	assign wr_idx = resolve_i.pc[GW+1:2];

	assign rd_choice  = choice_tbl[rd_idx];
	assign use_global = rd_choice[1];

	assign final_taken = use_global ? global_taken_i : local_taken_i;

	//******************************
	// snapshot
	//******************************
	// history is the value before this lookup shifts it
	always_comb begin
		predict_o.taken        = final_taken;
		predict_o.local_taken  = local_taken_i;
		predict_o.global_taken = global_taken_i;
		predict_o.ghr          = ghr_i;
	end

	//******************************
	// choice training
	//******************************
	// reset state WEAK_NT selects local
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < CH_SIZE; i++) begin
				choice_tbl[i] <= bp_pkg::WEAK_NT;
			end
		end else if (upd_i) begin
			choice_tbl[wr_idx] <= bp_pkg::ctr_step(choice_tbl[wr_idx], prefer_global_i);
		end
	end

	// final direction always comes from one of the two tables
	a_taken_from_source: assert property (@(posedge clk) disable iff (!rst_n_i)
		(predict_o.taken == local_taken_i) || (predict_o.taken == global_taken_i));

endmodule

/* logic/tournament_predictor.sv */
`timescale 1ns/100ps

module tournament_predictor #(
	parameter int LOCAL_IDX_W = 6
) (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                lookup_i,
	input  bp_pkg::pc_t         lookup_pc_i,
	input  logic                resolve_valid_i,
	input  bp_pkg::bp_resolve_t resolve_i,
	output bp_pkg::bp_predict_t predict_o
);

	bp_pkg::ghr_t ghr;
	logic         upd_tables;
	logic         upd_choice;
	logic         prefer_global;
	logic         local_taken;
	logic         global_taken;

	//******************************
	// control
	//******************************
	history_ctrl u_history_ctrl (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.lookup_i        (lookup_i),
		.predict_taken_i (predict_o.taken),
		.resolve_valid_i (resolve_valid_i),
		.resolve_i       (resolve_i),
		.ghr_o           (ghr),
		.upd_tables_o    (upd_tables),
		.upd_choice_o    (upd_choice),
		.prefer_global_o (prefer_global)
	);

	//******************************
	// tables
	//******************************
	local_predictor #(
		.LOCAL_IDX_W (LOCAL_IDX_W)
	) u_local_predictor (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.lookup_pc_i   (lookup_pc_i),
		.upd_i         (upd_tables),
		.resolve_i     (resolve_i),
		.local_taken_o (local_taken)
	);

	gshare_predictor u_gshare_predictor (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.lookup_pc_i    (lookup_pc_i),
		.ghr_i          (ghr),
		.upd_i          (upd_tables),
		.resolve_i      (resolve_i),
		.global_taken_o (global_taken)
	);

	// final choice and snapshot
	tournament_select u_tournament_select (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.lookup_pc_i     (lookup_pc_i),
		.ghr_i           (ghr),
		.local_taken_i   (local_taken),
		.global_taken_i  (global_taken),
		.upd_i           (upd_choice),
		.prefer_global_i (prefer_global),
		.resolve_i       (resolve_i),
		.predict_o       (predict_o)
	);

endmodule

/* test/bp_check_tasks.svh */
`ifndef BP_CHECK_TASKS_SVH
`define BP_CHECK_TASKS_SVH

//******************************
// compare tasks
//******************************

// direction bits of a prediction snapshot, history is checked apart
task automatic check_predict(
	input string               what,
	input bp_pkg::bp_predict_t got,
	input bp_pkg::bp_predict_t exp
);
	if (got.local_taken !== exp.local_taken) begin
		$display("ERR t=%0t %s.local_taken got %b exp %b", $time, what,
			got.local_taken, exp.local_taken);
		err_count++;
	end
	if (got.global_taken !== exp.global_taken) begin
		$display("ERR t=%0t %s.global_taken got %b exp %b", $time, what,
			got.global_taken, exp.global_taken);
		err_count++;
	end
	if (got.taken !== exp.taken) begin
		$display("ERR t=%0t %s.taken got %b exp %b", $time, what, got.taken, exp.taken);
		err_count++;
	end
endtask

// history value seen at lookup
task automatic check_ghr(
	input string        what,
	input bp_pkg::ghr_t got,
	input bp_pkg::ghr_t exp
);
	if (got !== exp) begin
		$display("ERR t=%0t %s got %h exp %h", $time, what, got, exp);
		err_count++;
	end
endtask

`endif

/* test/tb_tournament_predictor.sv */
`timescale 1ns/100ps

module tb_tournament_predictor;

	localparam int LOCAL_IDX_W = 6;
	localparam int MAX_LINES   = 256;
	localparam int POLL_LIMIT  = 6;

	// one step of the vector file
	typedef struct packed {
		logic [7:0]          test_id;
		logic                defer;
		bp_pkg::pc_t         pc;
		logic                actual;
		bp_pkg::bp_predict_t exp;
	} vec_t;

	logic                clk;
	logic                rst_n;
	logic                lookup;
	bp_pkg::pc_t         lookup_pc;
	logic                resolve_valid;
	bp_pkg::bp_resolve_t resolve;
	bp_pkg::bp_predict_t predict;

	vec_t vecs[$];
	int   err_count;
	logic timed_out;

	`include "bp_check_tasks.svh"

	tournament_predictor #(
		.LOCAL_IDX_W (LOCAL_IDX_W)
	) uut (
		.clk             (clk),
		.rst_n_i         (rst_n),
		.lookup_i        (lookup),
		.lookup_pc_i     (lookup_pc),
		.resolve_valid_i (resolve_valid),
		.resolve_i       (resolve),
		.predict_o       (predict)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//******************************
	// helpers
	//******************************
	task automatic next_drive_point();
		@(posedge clk);
		#2;
	endtask

	// prediction is combinational, poll inside the lookup cycle only
	task automatic wait_prediction(output logic ok);
		int tries;
		tries = 0;
		#1;
		while ($isunknown(predict) && tries < POLL_LIMIT) begin
			#1;
			tries++;
		end
		ok = !$isunknown(predict);
	endtask

	task automatic report_test(input logic [7:0] id, input int steps, input int errs);
		$display("test %0d: %0d steps, %0d mismatches, %s", id, steps, errs,
			(errs == 0) ? "ok" : "failed");
	endtask

	task automatic load_vectors();
		int          fd;
		int          rc;
		int          lines;
		logic        done;
		string       line;
		vec_t        v;
		logic [7:0]  tid;
		logic        dfr;
		bp_pkg::pc_t pc;
		logic        act;
		logic        lt;
		logic        gt;
		logic        tk;
		bp_pkg::ghr_t gh;
		fd = $fopen("test/bp_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file test/bp_vectors.txt");
			err_count++;
		end else begin
			lines = 0;
			done  = 1'b0;
			while (!done && lines < MAX_LINES) begin
				line = "";
				rc = $fgets(line, fd);
				lines++;
				if (rc == 0) begin
					done = 1'b1;
				end else if (line.len() > 1 && line.getc(0) != "#") begin
					rc = $sscanf(line, "%d %d %h %d %d %d %d %h",
						tid, dfr, pc, act, lt, gt, tk, gh);
					if (rc == 8) begin
						v.test_id          = tid;
						v.defer            = dfr;
						v.pc               = pc;
						v.actual           = act;
						v.exp.local_taken  = lt;
						v.exp.global_taken = gt;
						v.exp.taken        = tk;
						v.exp.ghr          = gh;
						vecs.push_back(v);
					end else begin
						$display("malformed line in the vector file: %s", line);
						err_count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	//******************************
	// stimulus
	//******************************
	initial begin
		vec_t                v;
		bp_pkg::bp_predict_t snap;
		bp_pkg::bp_resolve_t res;
		bp_pkg::bp_resolve_t pending_res;
		logic                pending;
		logic                ok;
		logic [7:0]          cur_test;
		int                  test_errs;
		int                  test_steps;
		int                  tests_done;
		int unsigned         gap;
		int unsigned         seed_init;
		rst_n         = 1'b0;
		lookup        = 1'b0;
		lookup_pc     = '0;
		resolve_valid = 1'b0;
		resolve       = '0;
		err_count     = 0;
		timed_out     = 1'b0;
		pending       = 1'b0;
		pending_res   = '0;
		cur_test      = '0;
		test_errs     = 0;
		test_steps    = 0;
		tests_done    = 0;
		seed_init     = $urandom(32'h4d4047b3);
		load_vectors();
		if (vecs.size() == 0) begin
			$display("no steps were read from the vector file");
			err_count++;
		end
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < vecs.size() && !timed_out; i++) begin
			v = vecs[i];
			if (v.test_id != cur_test) begin
				if (test_steps > 0) begin
					report_test(cur_test, test_steps, err_count - test_errs);
					tests_done++;
				end
				cur_test   = v.test_id;
				test_steps = 0;
				test_errs  = err_count;
			end
			gap = $urandom_range(2, 0);
			repeat (gap) next_drive_point();
			// lookup cycle, a deferred resolve rides along
			lookup    = 1'b1;
			lookup_pc = v.pc;
			if (pending) begin
				resolve_valid = 1'b1;
				resolve       = pending_res;
				pending       = 1'b0;
			end
			wait_prediction(ok);
			if (!ok) begin
				$display("timeout: predict_o stayed unknown after a lookup at pc %h", v.pc);
				timed_out = 1'b1;
			end else begin
				snap = predict;
				check_predict("predict_o", snap, v.exp);
				check_ghr("predict_o.ghr", snap.ghr, v.exp.ghr);
				test_steps++;
				next_drive_point();
				lookup        = 1'b0;
				resolve_valid = 1'b0;
				res.pc        = v.pc;
				res.taken     = v.actual;
				res.pred      = snap;
				if (v.defer) begin
					pending_res = res;
					pending     = 1'b1;
				end else begin
					resolve_valid = 1'b1;
					resolve       = res;
					next_drive_point();
					resolve_valid = 1'b0;
				end
			end
		end
		if (test_steps > 0) begin
			report_test(cur_test, test_steps, err_count - test_errs);
			tests_done++;
		end
		if (pending && !timed_out) begin
			resolve_valid = 1'b1;
			resolve       = pending_res;
			next_drive_point();
			resolve_valid = 1'b0;
		end
		repeat (2) next_drive_point();
		$display("summary: %0d tests, %0d steps, %0d errors", tests_done, vecs.size(),
			err_count);
		if (err_count == 0 && !timed_out) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* test/bp_vectors.txt */
# test defer pc actual exp_local exp_global exp_taken exp_ghr
# defer 1 holds the resolve back until the next lookup cycle
# reset state
1 0 00000100 0 0 0 0 00
1 0 20000a0c 0 0 0 0 00
# always taken branch, local flips first
2 0 00000040 1 0 0 0 00
2 0 00000040 1 1 0 1 01
2 0 00000040 1 1 0 1 03
# back to back lookups shift in the predicted bit
3 1 00000040 1 1 0 1 07
3 0 00000308 0 0 0 0 0f
3 0 00000308 0 0 0 0 1e
# mispredict repair of the history
4 0 00000414 1 0 0 0 3c
4 0 00000414 0 1 0 1 79
4 0 00000414 0 0 0 0 f2
# alternating branch, choice moves toward global
5 0 00000860 1 0 0 0 e4
5 0 00000860 0 1 0 1 c9
5 0 00000860 1 0 0 0 92
5 0 00000860 0 1 0 0 25
5 0 00000860 1 0 0 0 4a
5 0 00000860 0 1 0 0 95
# lookup and resolve of the same pc in one cycle
6 1 00000c24 1 0 0 0 2a
6 0 00000c24 1 0 0 0 54
6 0 00000c24 1 1 0 1 a9
# gshare entry trained by another branch
7 0 00000004 1 0 1 0 53

/* tournament_predictor.f */
logic/bp_pkg.sv
logic/history_ctrl.sv
logic/local_predictor.sv
logic/gshare_predictor.sv
logic/tournament_select.sv
logic/tournament_predictor.sv
+incdir+test
test/tb_tournament_predictor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the predictor testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_tournament_predictor \
	-f tournament_predictor.f \
	-o tb_tournament_predictor

./obj_dir/tb_tournament_predictor 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi
echo "simulation finished without failures"
